//--- testbench/sq_trace.txt
# command, then six hex operands p0..p5 (unused ones are 0)
# alloc: idx full | addr, data: idx value size | load: idx addr mask fwd_mask fwd_data stall
# drain: addr mask data | quiet: cycles | status: full commit_empty | idle, commit: none
status 0 1 0 0 0 0
alloc 0 0 0 0 0 0
commit 0 0 0 0 0 0
alloc 1 0 0 0 0 0
alloc 2 0 0 0 0 0
alloc 3 0 0 0 0 0
alloc 4 0 0 0 0 0
alloc 5 0 0 0 0 0
alloc 6 0 0 0 0 0
alloc 7 0 0 0 0 0
status 1 0 0 0 0 0
alloc 8 1 0 0 0 0
status 1 0 0 0 0 0
addr 5 40000000 2 0 0 0
data 5 11223344 2 0 0 0
addr 6 40000002 1 0 0 0
addr 7 40000001 0 0 0 0
load 8 40000000 2 2 0 1
load 8 40000000 1 1 00000044 0
data 6 0000aabb 1 0 0 0
data 7 000000cc 0 0 0 0
load 7 40000000 7 7 00bb3344 0
load 8 40000000 f f aabbcc44 0
load 8 50000000 f 0 0 0
load 6 40000002 f f 11223344 0
idle 0 0 0 0 0 0
addr 0 10000001 0 0 0 0
quiet 6 0 0 0 0 0
addr 1 10000006 1 0 0 0
data 1 0000beef 1 0 0 0
commit 0 0 0 0 0 0
quiet 6 0 0 0 0 0
data 0 000000a5 0 0 0 0
drain 10000000 2 a5a5a5a5 0 0 0
drain 10000004 c beefbeef 0 0 0
status 0 1 0 0 0 0
addr 2 20000008 2 0 0 0
data 2 12345678 2 0 0 0
quiet 6 0 0 0 0 0
commit 0 0 0 0 0 0
drain 20000008 f 12345678 0 0 0
addr 3 20000003 0 0 0 0
data 3 0000003c 0 0 0 0
addr 4 30000000 3 0 0 0
data 4 cafef00d 3 0 0 0
commit 0 0 0 0 0 0
commit 0 0 0 0 0 0
commit 0 0 0 0 0 0
commit 0 0 0 0 0 0
commit 0 0 0 0 0 0
drain 20000000 8 3c3c3c3c 0 0 0
drain 30000000 f cafef00d 0 0 0
drain 40000000 f 11223344 0 0 0
drain 40000000 c aabbaabb 0 0 0
drain 40000000 2 cccccccc 0 0 0
status 0 1 0 0 0 0
alloc 8 0 0 0 0 0
addr 0 60000004 1 0 0 0
data 0 00001234 1 0 0 0
alloc 9 0 0 0 0 0
load 9 60000004 f 3 00001234 0
commit 0 0 0 0 0 0
drain 60000004 3 12341234 0 0 0
status 0 1 0 0 0 0

//--- files.f
verilog/sq_pkg.sv
verilog/sq_if.sv
verilog/sq_pointers.sv
verilog/sq_entry_array.sv
verilog/sq_forward.sv
verilog/sq_drain.sv
verilog/store_queue_top.sv
testbench/store_queue_sva.sv
testbench/tb_store_queue.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_store_queue \
    -f files.f \
    -o sim_store_queue

./obj_dir/sim_store_queue | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

//--- testbench/tb_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_store_queue import sq_pkg::*; ();

    localparam int SQ_DEPTH = 8;
    localparam int IDX_W = $clog2(SQ_DEPTH);
    localparam int DRAIN_TIMEOUT = 50;

    logic             clk;
    logic             rst;
    logic             alloc_i;
    logic             full_o;
    logic [IDX_W:0]   alloc_idx_o;
    logic             addr_wr_i;
    logic [IDX_W-1:0] addr_idx_i;
    paddr_t           addr_i;
    mem_size_t        addr_size_i;
    logic             data_wr_i;
    logic [IDX_W-1:0] data_idx_i;
    word_t            data_i;
    mem_size_t        data_size_i;
    logic             commit_i;
    logic             commit_empty_o;
    logic             ld_req_i;
    logic [IDX_W:0]   ld_sq_idx_i;
    word_addr_t       ld_addr_i;
    byte_mask_t       ld_mask_i;
    logic             ld_valid_o;
    byte_mask_t       ld_fwd_mask_o;
    word_t            ld_fwd_data_o;
    logic             ld_stall_o;
    logic             mem_wr_o;
    paddr_t           mem_addr_o;
    byte_mask_t       mem_mask_o;
    word_t            mem_data_o;

    // observed memory writes as {addr, mask, data}
    logic [67:0] wr_q[$];
    int          check_count = 0;
    int          error_count = 0;
    int          fail_count = 0;

    store_queue_top #(.SQ_DEPTH(SQ_DEPTH)) store_queue_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst && mem_wr_o) begin
            wr_q.push_back({mem_addr_o, mem_mask_o, mem_data_o});
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic clear_strobes();
        alloc_i <= 1'b0;
        addr_wr_i <= 1'b0;
        data_wr_i <= 1'b0;
        commit_i <= 1'b0;
        ld_req_i <= 1'b0;
    endtask

    task automatic wait_for_write(input logic [31:0] addr, input logic [31:0] mask,
                                  input logic [31:0] data);
        logic [67:0] wr;
        int          n;
        n = 0;
        while (wr_q.size() == 0 && n < DRAIN_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (wr_q.size() == 0) begin
            fail_count++;
            $display("No memory write arrived within %0d cycles, time %0t", DRAIN_TIMEOUT, $time);
        end else begin
            wr = wr_q.pop_front();
            check_value("mem_addr_o", wr[67:36], addr);
            check_value("mem_mask_o", 32'(wr[35:32]), mask);
            check_value("mem_data_o", wr[31:0], data);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(posedge clk);
        if (wr_q.size() != 0) begin
            fail_count++;
            $display("A memory write came out while none was allowed, time %0t", $time);
            wr_q.delete();
        end
    endtask

    task automatic run_command(input string cmd, input logic [31:0] p0, input logic [31:0] p1,
                               input logic [31:0] p2, input logic [31:0] p3,
                               input logic [31:0] p4, input logic [31:0] p5);
        @(posedge clk);
        clear_strobes();
        case (cmd)
            "idle": begin
            end
            "alloc": begin
                alloc_i <= 1'b1;
                @(negedge clk);
                check_value("alloc_idx_o", 32'(alloc_idx_o), p0);
                check_value("full_o", 32'(full_o), p1);
            end
            "addr": begin
                addr_wr_i <= 1'b1;
                addr_idx_i <= p0[IDX_W-1:0];
                addr_i <= p1;
                addr_size_i <= p2[1:0];
            end
            "data": begin
                data_wr_i <= 1'b1;
                data_idx_i <= p0[IDX_W-1:0];
                data_i <= p1;
                data_size_i <= p2[1:0];
            end
            "commit": begin
                commit_i <= 1'b1;
            end
            "load": begin
                ld_req_i <= 1'b1;
                ld_sq_idx_i <= p0[IDX_W:0];
                ld_addr_i <= p1[31:2];
                ld_mask_i <= p2[3:0];
                @(posedge clk);
                clear_strobes();
                @(negedge clk);
                check_value("ld_valid_o", 32'(ld_valid_o), 32'd1);
                check_value("ld_fwd_mask_o", 32'(ld_fwd_mask_o), p3);
                check_value("ld_stall_o", 32'(ld_stall_o), p5);
                // bytes of a store still waiting for data carry no value
                if (p5 == 32'd0) begin
                    check_value("ld_fwd_data_o", ld_fwd_data_o, p4);
                end
            end
            "drain": begin
                wait_for_write(p0, p1, p2);
            end
            "quiet": begin
                expect_quiet(int'(p0));
            end
            "status": begin
                @(negedge clk);
                check_value("full_o", 32'(full_o), p0);
                check_value("commit_empty_o", 32'(commit_empty_o), p1);
            end
            default: begin
                fail_count++;
                $display("Unknown command %s in the trace file", cmd);
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          count;
        string       line;
        string       cmd;
        logic [31:0] p0;
        logic [31:0] p1;
        logic [31:0] p2;
        logic [31:0] p3;
        logic [31:0] p4;
        logic [31:0] p5;
        rst = 1'b1;
        alloc_i = 1'b0;
        addr_wr_i = 1'b0;
        addr_idx_i = '0;
        addr_i = '0;
        addr_size_i = '0;
        data_wr_i = 1'b0;
        data_idx_i = '0;
        data_i = '0;
        data_size_i = '0;
        commit_i = 1'b0;
        ld_req_i = 1'b0;
        ld_sq_idx_i = '0;
        ld_addr_i = '0;
        ld_mask_i = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("testbench/sq_trace.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("Could not open the trace file testbench/sq_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                count = $fgets(line, fd);
                if (count > 0 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%s %h %h %h %h %h %h", cmd, p0, p1, p2, p3, p4, p5);
                    if (count == 7) begin
                        run_command(cmd, p0, p1, p2, p3, p4, p5);
                    end else if (count > 0) begin
                        fail_count++;
                        $display("Trace line does not hold seven fields: %s", line);
                    end
                end
            end
            $fclose(fd);
        end

        // anything still queued here was never expected
        expect_quiet(10);
        $display("checks %0d, value errors %0d, other failures %0d",
                 check_count, error_count, fail_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/store_queue_sva.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue_sva import sq_pkg::*; #(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH)
) (
    input logic             clk,
    input logic             rst,
    input logic [IDX_W-1:0] head_i,
    input logic             mem_wr_i,
    input paddr_t           mem_addr_i,
    input logic             full_i,
    input logic             commit_empty_i,
    input logic             ld_req_i,
    input logic             ld_valid_i
);

    // every drain moves head, so a second write with head still would repeat an entry
    repeat_write_a: assert property (@(posedge clk) disable iff (rst)
        (mem_wr_i && $past(mem_wr_i) && $stable(head_i)) |-> !$stable(mem_addr_i))
        else $error("memory write repeated on one address without a head move");

    full_cempty_a: assert property (@(posedge clk) disable iff (rst)
        !(full_i && commit_empty_i))
        else $error("full and commit empty raised together");

    ld_valid_a: assert property (@(posedge clk) disable iff (rst)
        ld_valid_i == $past(ld_req_i))
        else $error("load answer not one cycle after its request");

endmodule

bind store_queue_top store_queue_sva #(.SQ_DEPTH(SQ_DEPTH)) store_queue_sva_inst (
    .clk            (clk),
    .rst            (rst),
    .head_i         (ptr_if.head),
    .mem_wr_i       (mem_wr_o),
    .mem_addr_i     (mem_addr_o),
    .full_i         (full_o),
    .commit_empty_i (commit_empty_o),
    .ld_req_i       (ld_req_i),
    .ld_valid_i     (ld_valid_o)
);

`default_nettype wire

//--- verilog/store_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue_top import sq_pkg::*; #(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_i,
    output logic             full_o,
    output logic [IDX_W:0]   alloc_idx_o,
    input  logic             addr_wr_i,
    input  logic [IDX_W-1:0] addr_idx_i,
    input  paddr_t           addr_i,
    input  mem_size_t        addr_size_i,
    input  logic             data_wr_i,
    input  logic [IDX_W-1:0] data_idx_i,
    input  word_t            data_i,
    input  mem_size_t        data_size_i,
    input  logic             commit_i,
    output logic             commit_empty_o,
    input  logic             ld_req_i,
    input  logic [IDX_W:0]   ld_sq_idx_i,
    input  word_addr_t       ld_addr_i,
    input  byte_mask_t       ld_mask_i,
    output logic             ld_valid_o,
    output byte_mask_t       ld_fwd_mask_o,
    output word_t            ld_fwd_data_o,
    output logic             ld_stall_o,
    output logic             mem_wr_o,
    output paddr_t           mem_addr_o,
    output byte_mask_t       mem_mask_o,
    output word_t            mem_data_o
);

    sq_ptr_if #(.SQ_DEPTH(SQ_DEPTH)) ptr_if ();
    sq_entry_if #(.SQ_DEPTH(SQ_DEPTH)) ent_if ();

    sq_pointers #(.SQ_DEPTH(SQ_DEPTH)) sq_pointers_inst (
        .clk            (clk),
        .rst            (rst),
        .alloc_i        (alloc_i),
        .commit_i       (commit_i),
        .full_o         (full_o),
        .commit_empty_o (commit_empty_o),
        .alloc_idx_o    (alloc_idx_o),
        .ptr            (ptr_if.owner)
    );

    sq_entry_array #(.SQ_DEPTH(SQ_DEPTH)) sq_entry_array_inst (
        .clk         (clk),
        .rst         (rst),
        .addr_wr_i   (addr_wr_i),
        .addr_idx_i  (addr_idx_i),
        .addr_i      (addr_i),
        .addr_size_i (addr_size_i),
        .data_wr_i   (data_wr_i),
        .data_idx_i  (data_idx_i),
        .data_i      (data_i),
        .data_size_i (data_size_i),
        .ptr         (ptr_if.array),
        .ent         (ent_if.store)
    );

    sq_forward #(.SQ_DEPTH(SQ_DEPTH)) sq_forward_inst (
        .clk           (clk),
        .rst           (rst),
        .ld_req_i      (ld_req_i),
        .ld_sq_idx_i   (ld_sq_idx_i),
        .ld_addr_i     (ld_addr_i),
        .ld_mask_i     (ld_mask_i),
        .ld_valid_o    (ld_valid_o),
        .ld_fwd_mask_o (ld_fwd_mask_o),
        .ld_fwd_data_o (ld_fwd_data_o),
        .ld_stall_o    (ld_stall_o),
        .ptr           (ptr_if.fwd),
        .ent           (ent_if.reader)
    );

    sq_drain #(.SQ_DEPTH(SQ_DEPTH)) sq_drain_inst (
        .clk        (clk),
        .rst        (rst),
        .mem_wr_o   (mem_wr_o),
        .mem_addr_o (mem_addr_o),
        .mem_mask_o (mem_mask_o),
        .mem_data_o (mem_data_o),
        .ptr        (ptr_if.drain),
        .ent        (ent_if.reader)
    );

endmodule

`default_nettype wire

//--- verilog/sq_drain.sv
`timescale 1ns/1ps
`default_nettype none

module sq_drain import sq_pkg::*; #(
    parameter int SQ_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst,
    output logic       mem_wr_o,
    output paddr_t     mem_addr_o,
    output byte_mask_t mem_mask_o,
    output word_t      mem_data_o,
    sq_ptr_if.drain    ptr,
    sq_entry_if.reader ent
);

    logic head_ready;

    // head must be allocated, complete and committed
    assign head_ready = ent.valid[ptr.head] & ent.addr_valid[ptr.head]
                      & ent.data_valid[ptr.head] & ent.committed[ptr.head];

    assign ptr.pop = head_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wr_o <= 1'b0;
        end else begin
            mem_wr_o <= head_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (head_ready) begin
            mem_addr_o <= {ent.word_addr[ptr.head], {OFFSET_W{1'b0}}};
            mem_mask_o <= ent.byte_mask[ptr.head];
            mem_data_o <= ent.data[ptr.head];
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_forward.sv
`timescale 1ns/1ps
`default_nettype none

module sq_forward import sq_pkg::*; #(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH)
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           ld_req_i,
    input  logic [IDX_W:0] ld_sq_idx_i,
    input  word_addr_t     ld_addr_i,
    input  byte_mask_t     ld_mask_i,
    output logic           ld_valid_o,
    output byte_mask_t     ld_fwd_mask_o,
    output word_t          ld_fwd_data_o,
    output logic           ld_stall_o,
    sq_ptr_if.fwd          ptr,
    sq_entry_if.reader     ent
);

    logic [IDX_W:0]      ld_dist;
    logic [IDX_W:0]      tail_dist;
    logic [IDX_W:0]      limit;
    logic [SQ_DEPTH-1:0] cand;
    byte_mask_t          fwd_mask;
    word_t               fwd_data;
    logic                stall;

    // distances from head, wrap bits included
    assign ld_dist = ld_sq_idx_i - {ptr.head_dir, ptr.head};
    assign tail_dist = {ptr.tail_dir, ptr.tail} - {ptr.head_dir, ptr.head};
    // never look past the allocated region
    assign limit = (ld_dist > tail_dist) ? tail_dist : ld_dist;

    always_comb begin
        logic [IDX_W-1:0] age;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            age = IDX_W'(i) - ptr.head;
            cand[i] = ent.valid[i] && ent.addr_valid[i]
                   && (ent.word_addr[i] == ld_addr_i) && ({1'b0, age} < limit);
        end
    end

    always_comb begin
        logic [IDX_W-1:0] idx;
        logic             hit;
        fwd_mask = '0;
        fwd_data = '0;
        stall = 1'b0;
        for (int b = 0; b < XLEN_BYTES; b++) begin
            hit = 1'b0;
            // youngest first, first hit owns the byte
            for (int k = SQ_DEPTH - 1; k >= 0; k--) begin
                idx = ptr.head + IDX_W'(k);
                if (!hit && cand[idx] && ld_mask_i[b] && ent.byte_mask[idx][b]) begin
                    hit = 1'b1;
                    fwd_mask[b] = 1'b1;
                    fwd_data[8*b +: 8] = ent.data[idx][8*b +: 8];
                    stall = stall | ~ent.data_valid[idx];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ld_valid_o <= 1'b0;
            ld_stall_o <= 1'b0;
        end else begin
            ld_valid_o <= ld_req_i;
            ld_stall_o <= ld_req_i & stall;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_req_i) begin
            ld_fwd_mask_o <= fwd_mask;
            ld_fwd_data_o <= fwd_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module sq_entry_array import sq_pkg::*; #(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             addr_wr_i,
    input  logic [IDX_W-1:0] addr_idx_i,
    input  paddr_t           addr_i,
    input  mem_size_t        addr_size_i,
    input  logic             data_wr_i,
    input  logic [IDX_W-1:0] data_idx_i,
    input  word_t            data_i,
    input  mem_size_t        data_size_i,
    sq_ptr_if.array          ptr,
    sq_entry_if.store        ent
);

    byte_mask_t size_mask;
    byte_mask_t wr_mask;
    word_t      wr_data;

    // byte enables from size, then moved up to the byte offset
    always_comb begin
        case (addr_size_i)
            SIZE_BYTE: size_mask = byte_mask_t'(4'b0001);
            SIZE_HALF: size_mask = byte_mask_t'(4'b0011);
            default:   size_mask = byte_mask_t'(4'b1111);
        endcase
        wr_mask = size_mask << addr_i[OFFSET_W-1:0];
    end

    // replicate so every lane holds the store value
    always_comb begin
        case (data_size_i)
            SIZE_BYTE: wr_data = {XLEN_BYTES{data_i[7:0]}};
            SIZE_HALF: wr_data = {(XLEN_BYTES / 2){data_i[15:0]}};
            default:   wr_data = data_i;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent.valid <= '0;
            ent.addr_valid <= '0;
            ent.data_valid <= '0;
            ent.committed <= '0;
        end else begin
            if (ptr.pop) begin
                ent.valid[ptr.head] <= 1'b0;
            end
            if (ptr.alloc_fire) begin
                ent.valid[ptr.tail] <= 1'b1;
                ent.addr_valid[ptr.tail] <= 1'b0;
                ent.data_valid[ptr.tail] <= 1'b0;
                ent.committed[ptr.tail] <= 1'b0;
            end
            // writes and commit land after the allocation clear
            if (addr_wr_i) begin
                ent.addr_valid[addr_idx_i] <= 1'b1;
            end
            if (data_wr_i) begin
                ent.data_valid[data_idx_i] <= 1'b1;
            end
            if (ptr.commit_fire) begin
                ent.committed[ptr.commit_ptr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_wr_i) begin
            ent.word_addr[addr_idx_i] <= addr_i[PADDR_W-1:OFFSET_W];
            ent.byte_mask[addr_idx_i] <= wr_mask;
        end
        if (data_wr_i) begin
            ent.data[data_idx_i] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_pointers.sv
`timescale 1ns/1ps
`default_nettype none

module sq_pointers #(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH)
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           alloc_i,
    input  logic           commit_i,
    output logic           full_o,
    output logic           commit_empty_o,
    output logic [IDX_W:0] alloc_idx_o,
    sq_ptr_if.owner        ptr
);

    // top bit of each pointer is its wrap bit
    logic [IDX_W:0] head_q;
    logic [IDX_W:0] tail_q;
    logic [IDX_W:0] commit_q;

    // same slot, different lap
    assign full_o = (tail_q[IDX_W-1:0] == head_q[IDX_W-1:0])
                 && (tail_q[IDX_W] != head_q[IDX_W]);

    assign commit_empty_o = (commit_q == head_q);
    assign alloc_idx_o = tail_q;

    assign ptr.alloc_fire = alloc_i & ~full_o;
    assign ptr.commit_fire = commit_i;

    assign ptr.head = head_q[IDX_W-1:0];
    assign ptr.head_dir = head_q[IDX_W];
    assign ptr.tail = tail_q[IDX_W-1:0];
    assign ptr.tail_dir = tail_q[IDX_W];
    assign ptr.commit_ptr = commit_q[IDX_W-1:0];

    // depth is a power of two, so the carry out of the index flips the wrap bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            commit_q <= '0;
        end else begin
            if (ptr.alloc_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (ptr.commit_fire) begin
                commit_q <= commit_q + 1'b1;
            end
            if (ptr.pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sq_ptr_if #(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH)
);
    logic [IDX_W-1:0] head;
    logic             head_dir;
    logic [IDX_W-1:0] tail;
    logic             tail_dir;
    logic [IDX_W-1:0] commit_ptr;
    logic             alloc_fire;
    logic             commit_fire;
    logic             pop;

    modport owner (
        output head, head_dir, tail, tail_dir, commit_ptr, alloc_fire, commit_fire,
        input  pop
    );
    // head is needed here so a drained entry can be released
    modport array (input head, tail, commit_ptr, alloc_fire, commit_fire, pop);
    modport drain (input head, output pop);
    modport fwd (input head, head_dir, tail, tail_dir);
endinterface

interface sq_entry_if import sq_pkg::*; #(
    parameter int SQ_DEPTH = 8
);
    logic [SQ_DEPTH-1:0] valid;
    logic [SQ_DEPTH-1:0] addr_valid;
    logic [SQ_DEPTH-1:0] data_valid;
    logic [SQ_DEPTH-1:0] committed;
    word_addr_t          word_addr [SQ_DEPTH];
    byte_mask_t          byte_mask [SQ_DEPTH];
    word_t               data      [SQ_DEPTH];

    modport store (output valid, addr_valid, data_valid, committed, word_addr, byte_mask, data);
    modport reader (input valid, addr_valid, data_valid, committed, word_addr, byte_mask, data);
endinterface

`default_nettype wire

//--- verilog/sq_pkg.sv
`default_nettype none

package sq_pkg;

    localparam int XLEN = 32;
    localparam int XLEN_BYTES = 4;
    localparam int PADDR_W = 32;
    // byte offset bits inside a data word
    localparam int OFFSET_W = $clog2(XLEN_BYTES);
    localparam int WORD_ADDR_W = PADDR_W - OFFSET_W;

    typedef logic [XLEN-1:0]        word_t;
    typedef logic [PADDR_W-1:0]     paddr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [XLEN_BYTES-1:0]  byte_mask_t;
    typedef logic [1:0]             mem_size_t;

    // access size encodings, 3 behaves like a word
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

endpackage

`default_nettype wire
